//--- src/stream_defines.svh
// Stream widths and buffer depth shared by RTL and testbench
// FIFO_DEPTH must be a power of two, and widths must be nonzero

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

////////////////////////////////////////////////////////////
// Beat geometry

// Bytes per beat, one 64-bit word
`define STREAM_DATA_BYTES 8
// Sideband field widths
`define STREAM_ID_WIDTH   4
`define STREAM_DEST_WIDTH 4
`define STREAM_USER_WIDTH 8

////////////////////////////////////////////////////////////
// Buffer and status

// LUT-RAM entries, power of two
`define FIFO_DEPTH        32
// Width of each packet counter, wraps silently
`define PKT_COUNT_WIDTH   16

`endif

//--- src/stream_pkg.sv
// Beat type stored in the FIFO RAM, one word per stream transfer
// tstrb is not carried; every byte lane is treated as data or padding via keep

`include "stream_defines.svh"

package stream_pkg;

    ////////////////////////////////////////////////////////////
    // Derived widths

    // Data bus width in bits
    localparam int DATA_WIDTH = 8 * `STREAM_DATA_BYTES;

    ////////////////////////////////////////////////////////////
    // One stream beat

    // Field order sets the RAM word layout, data in the upper bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0]         data;
        logic [`STREAM_DATA_BYTES-1:0] keep;
        logic                          last;
        logic [`STREAM_ID_WIDTH-1:0]   id;
        logic [`STREAM_DEST_WIDTH-1:0] dest;
        logic [`STREAM_USER_WIDTH-1:0] user;
    } axis_beat_t;

    // Width of one RAM word
    localparam int BEAT_WIDTH = $bits(axis_beat_t);

endpackage

//--- src/axis_if.sv
// Internal valid/ready stream link carrying one packed beat
// Source holds valid and beat stable until the transfer edge

`timescale 1ns/1ps

interface axis_if;

    ////////////////////////////////////////////////////////////
    // Link signals

    // Driven by the source
    logic                   valid;
    // Driven by the sink
    logic                   ready;
    // Payload, all AXI-Stream fields packed together
    stream_pkg::axis_beat_t beat;

    ////////////////////////////////////////////////////////////
    // Views

    // Upstream side of the link
    modport source (
        output valid,
        output beat,
        input  ready
    );

    // Downstream side of the link
    modport sink (
        input  valid,
        input  beat,
        output ready
    );

endinterface

//--- src/axis_ingress.sv
// Input side adapter, handshake passes through with no added latency
// Overflow flag is sticky until reset; counter wraps at PKT_COUNT_WIDTH

`timescale 1ns/1ps
`include "stream_defines.svh"

module axis_ingress (
    input  logic                             clk_ifc,
    input  logic                             rst_n,
    input  logic                             s_tvalid,
    input  logic [stream_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic [`STREAM_DATA_BYTES-1:0]    s_tkeep,
    input  logic                             s_tlast,
    input  logic [`STREAM_ID_WIDTH-1:0]      s_tid,
    input  logic [`STREAM_DEST_WIDTH-1:0]    s_tdest,
    input  logic [`STREAM_USER_WIDTH-1:0]    s_tuser,
    output logic                             s_tready,
    axis_if.source                           in_stream,
    output logic [`PKT_COUNT_WIDTH-1:0]      pkts_in,
    output logic                             axis_in_overflow
);

    ////////////////////////////////////////////////////////////
    // Beat packing and handshake

    // Keep plus one, zero in the set bits when keep is 0..01..1
    logic [`STREAM_DATA_BYTES-1:0] keep_inc;

    assign keep_inc = s_tkeep + 1'b1;

    assign in_stream.valid     = s_tvalid;
    assign in_stream.beat.data = s_tdata;
    assign in_stream.beat.keep = s_tkeep;
    assign in_stream.beat.last = s_tlast;
    assign in_stream.beat.id   = s_tid;
    assign in_stream.beat.dest = s_tdest;
    assign in_stream.beat.user = s_tuser;

    // Ready comes straight from the buffer
    assign s_tready = in_stream.ready;

    ////////////////////////////////////////////////////////////
    // Packet count and overflow

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            pkts_in          <= '0;
            axis_in_overflow <= 1'b0;
        end else begin
            // One count per accepted end of packet
            if (s_tvalid && in_stream.ready && s_tlast) begin
                pkts_in <= pkts_in + 1'b1;
            end
            // Source offered a beat the buffer could not take
            if (s_tvalid && !in_stream.ready) begin
                axis_in_overflow <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Input protocol checks

    // Mid-packet beats are full width
    a_keep_full: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        s_tvalid && !s_tlast |-> &s_tkeep);

    // Final beat keeps a nonzero run of low bytes
    a_keep_tail: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        s_tvalid && s_tlast |-> (s_tkeep != '0) && ((s_tkeep & keep_inc) == '0));

    // Offered beat is not withdrawn while the buffer stalls
    a_valid_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        s_tvalid && !in_stream.ready |=> s_tvalid);

endmodule

//--- src/dist_ram_fifo.sv
// Show-ahead FIFO on LUT RAM, read data is combinational from the array
// Holds FIFO_DEPTH beats; ready stays low for the first edge after reset

`timescale 1ns/1ps
`include "stream_defines.svh"

module dist_ram_fifo (
    input  logic   clk_ifc,
    input  logic   rst_n,
    axis_if.sink   wr,
    axis_if.source rd
);

    ////////////////////////////////////////////////////////////
    // Sizing

    localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);

    // Depth must fill the address space for the wrap-bit scheme
    if ((1 << ADDR_WIDTH) != `FIFO_DEPTH) begin : g_depth_check
        $error("FIFO_DEPTH must be a power of two");
    end

    ////////////////////////////////////////////////////////////
    // Storage and pointers

    // No reset on the array so it maps to LUT RAM
    logic [stream_pkg::BEAT_WIDTH-1:0] mem [`FIFO_DEPTH];

    // Pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] occupancy;

    logic full;
    logic empty;
    logic init_done;
    logic wr_fire;
    logic rd_fire;

    ////////////////////////////////////////////////////////////
    // Status

    // Modular difference gives 0..FIFO_DEPTH
    assign occupancy = wr_ptr - rd_ptr;
    assign full      = (occupancy == (ADDR_WIDTH + 1)'(`FIFO_DEPTH));
    assign empty     = (wr_ptr == rd_ptr);

    // Write side opens one edge after reset release
    assign wr.ready = init_done && !full;
    assign rd.valid = !empty;

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    // Head of queue, visible as soon as it is written
    assign rd.beat = stream_pkg::axis_beat_t'(mem[rd_ptr[ADDR_WIDTH-1:0]]);

    ////////////////////////////////////////////////////////////
    // RAM write port

    always_ff @(posedge clk_ifc) begin
        if (wr_fire) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr.beat;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointer update

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointer safety

    // Upstream honours ready, so a write never lands on a full array
    a_no_overrun: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        wr.valid && wr.ready |-> occupancy < (ADDR_WIDTH + 1)'(`FIFO_DEPTH));

    // Downstream only pops real entries, so the count never wraps below zero
    a_no_underrun: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        rd_fire |=> occupancy < (ADDR_WIDTH + 1)'(`FIFO_DEPTH));

endmodule

//--- src/axis_egress.sv
// One-entry output register, isolates RAM read path from the pins
// Full throughput under continuous m_tready; counter wraps silently

`timescale 1ns/1ps
`include "stream_defines.svh"

module axis_egress (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    axis_if.sink                              in_beats,
    output logic                              m_tvalid,
    output logic [stream_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic [`STREAM_DATA_BYTES-1:0]     m_tkeep,
    output logic                              m_tlast,
    output logic [`STREAM_ID_WIDTH-1:0]       m_tid,
    output logic [`STREAM_DEST_WIDTH-1:0]     m_tdest,
    output logic [`STREAM_USER_WIDTH-1:0]     m_tuser,
    input  logic                              m_tready,
    output logic [`PKT_COUNT_WIDTH-1:0]       pkts_out
);

    ////////////////////////////////////////////////////////////
    // Output register

    // Payload only, validity lives in m_tvalid
    stream_pkg::axis_beat_t out_beat;

    // Take a new beat when empty or when the held one leaves
    assign in_beats.ready = !m_tvalid || m_tready;

    always_ff @(posedge clk_ifc) begin
        if (in_beats.valid && in_beats.ready) begin
            out_beat <= in_beats.beat;
        end
    end

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid <= 1'b0;
            pkts_out <= '0;
        end else begin
            if (in_beats.ready) begin
                m_tvalid <= in_beats.valid;
            end
            // Delivered end of packet
            if (m_tvalid && m_tready && m_tlast) begin
                pkts_out <= pkts_out + 1'b1;
            end
        end
    end

    // Unpack onto the pins
    assign m_tdata = out_beat.data;
    assign m_tkeep = out_beat.keep;
    assign m_tlast = out_beat.last;
    assign m_tid   = out_beat.id;
    assign m_tdest = out_beat.dest;
    assign m_tuser = out_beat.user;

    ////////////////////////////////////////////////////////////
    // Output protocol

    // Stalled beat is held unchanged
    a_out_hold: assert property (@(posedge clk_ifc) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(out_beat));

endmodule

//--- src/axis_packet_fifo.sv
// AXI-Stream packet buffer, single clock, capacity FIFO_DEPTH + 1 beats
// Latency 2 edges when empty; no tstrb, overflow only flags the input side

`timescale 1ns/1ps
`include "stream_defines.svh"

module axis_packet_fifo (
    input  logic                              clk_ifc,
    input  logic                              rst_n,
    // Input stream
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic [stream_pkg::DATA_WIDTH-1:0] s_tdata,
    input  logic [`STREAM_DATA_BYTES-1:0]     s_tkeep,
    input  logic                              s_tlast,
    input  logic [`STREAM_ID_WIDTH-1:0]       s_tid,
    input  logic [`STREAM_DEST_WIDTH-1:0]     s_tdest,
    input  logic [`STREAM_USER_WIDTH-1:0]     s_tuser,
    // Output stream
    output logic                              m_tvalid,
    input  logic                              m_tready,
    output logic [stream_pkg::DATA_WIDTH-1:0] m_tdata,
    output logic [`STREAM_DATA_BYTES-1:0]     m_tkeep,
    output logic                              m_tlast,
    output logic [`STREAM_ID_WIDTH-1:0]       m_tid,
    output logic [`STREAM_DEST_WIDTH-1:0]     m_tdest,
    output logic [`STREAM_USER_WIDTH-1:0]     m_tuser,
    // Status
    output logic                              axis_in_overflow,
    output logic [`PKT_COUNT_WIDTH-1:0]       pkts_in,
    output logic [`PKT_COUNT_WIDTH-1:0]       pkts_out
);

    ////////////////////////////////////////////////////////////
    // Internal links

    // Adapter into RAM
    axis_if in_stream ();
    // RAM into output register
    axis_if out_stream ();

    ////////////////////////////////////////////////////////////
    // Datapath

    axis_ingress u_ingress (
        .clk_ifc          (clk_ifc),
        .rst_n            (rst_n),
        .s_tvalid         (s_tvalid),
        .s_tdata          (s_tdata),
        .s_tkeep          (s_tkeep),
        .s_tlast          (s_tlast),
        .s_tid            (s_tid),
        .s_tdest          (s_tdest),
        .s_tuser          (s_tuser),
        .s_tready         (s_tready),
        .in_stream        (in_stream.source),
        .pkts_in          (pkts_in),
        .axis_in_overflow (axis_in_overflow)
    );

    dist_ram_fifo u_fifo (
        .clk_ifc (clk_ifc),
        .rst_n   (rst_n),
        .wr      (in_stream.sink),
        .rd      (out_stream.source)
    );

    axis_egress u_egress (
        .clk_ifc  (clk_ifc),
        .rst_n    (rst_n),
        .in_beats (out_stream.sink),
        .m_tvalid (m_tvalid),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tid    (m_tid),
        .m_tdest  (m_tdest),
        .m_tuser  (m_tuser),
        .m_tready (m_tready),
        .pkts_out (pkts_out)
    );

endmodule

//--- test/axis_beat_scoreboard.sv
// Expected-beat queue for the packet FIFO testbench
// Caller checks pending() before a compare; an empty queue is not handled here

`timescale 1ns/1ps

module axis_beat_scoreboard;

    ////////////////////////////////////////////////////////////
    // Model state

    // Beats accepted at the input, oldest first
    stream_pkg::axis_beat_t expected_q[$];

    ////////////////////////////////////////////////////////////
    // Access

    // Record one accepted input beat
    task automatic push_beat(input stream_pkg::axis_beat_t beat);
        expected_q.push_back(beat);
    endtask

    // Oldest expected beat against the delivered one, every field
    task automatic pop_compare(
        input  stream_pkg::axis_beat_t got,
        output bit                     match,
        output stream_pkg::axis_beat_t want
    );
        want  = expected_q.pop_front();
        match = (got === want);
    endtask

    // Beats still inside the DUT
    function automatic int pending();
        return expected_q.size();
    endfunction

endmodule

//--- test/axis_packet_fifo_tb.sv
// Reset, latency and fill checks, then 100 random packets against a queue model
// Stops at the first error; SEED sets the whole random sequence

`timescale 1ns/1ps
`include "stream_defines.svh"

module axis_packet_fifo_tb #(
    parameter int unsigned SEED = 32'hc23c08c4
);

    localparam int NUM_PKTS = 100;
    localparam int BYTES    = `STREAM_DATA_BYTES;

    ////////////////////////////////////////////////////////////
    // DUT ports

    logic                              clk_ifc = 1'b0;
    logic                              rst_n;
    logic                              s_tvalid;
    logic                              s_tready;
    logic [stream_pkg::DATA_WIDTH-1:0] s_tdata;
    logic [BYTES-1:0]                  s_tkeep;
    logic                              s_tlast;
    logic [`STREAM_ID_WIDTH-1:0]       s_tid;
    logic [`STREAM_DEST_WIDTH-1:0]     s_tdest;
    logic [`STREAM_USER_WIDTH-1:0]     s_tuser;
    logic                              m_tvalid;
    logic                              m_tready = 1'b0;
    logic [stream_pkg::DATA_WIDTH-1:0] m_tdata;
    logic [BYTES-1:0]                  m_tkeep;
    logic                              m_tlast;
    logic [`STREAM_ID_WIDTH-1:0]       m_tid;
    logic [`STREAM_DEST_WIDTH-1:0]     m_tdest;
    logic [`STREAM_USER_WIDTH-1:0]     m_tuser;
    logic                              axis_in_overflow;
    logic [`PKT_COUNT_WIDTH-1:0]       pkts_in;
    logic [`PKT_COUNT_WIDTH-1:0]       pkts_out;

    // Last beats seen by the model on each side
    logic [`PKT_COUNT_WIDTH-1:0] in_lasts  = '0;
    logic [`PKT_COUNT_WIDTH-1:0] out_lasts = '0;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 0;
    int          pkt_len [NUM_PKTS];
    int          stall_left    = 0;
    bit          monitor_on    = 1'b0;
    bit          random_stalls = 1'b0;
    bit          ready_hold    = 1'b0;

    axis_packet_fifo uut (.*);

    axis_beat_scoreboard sb ();

    // 8 ns period
    always #4 clk_ifc = ~clk_ifc;

    ////////////////////////////////////////////////////////////
    // Helpers

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] want);
        assert (got === want)
            else report_failure($sformatf("Fail %0t: %s is %0h, expected %0h",
                                          $time, what, got, want));
    endtask

    // Random payload; keep covers the low valid_bytes lanes
    function automatic stream_pkg::axis_beat_t random_beat(
        input int valid_bytes, input bit last,
        input logic [`STREAM_ID_WIDTH-1:0] id, input logic [`STREAM_DEST_WIDTH-1:0] dest
    );
        stream_pkg::axis_beat_t      b;
        logic [`STREAM_USER_WIDTH-1:0] user;
        user = `STREAM_USER_WIDTH'($urandom);
        for (int k = 0; k < BYTES; k++) begin
            b.data[8*k +: 8] = 8'($urandom);
            b.keep[k]        = (k < valid_bytes);
        end
        b.last = last;
        b.id   = id;
        b.dest = dest;
        b.user = user;
        return b;
    endfunction

    task automatic apply_beat(input stream_pkg::axis_beat_t b);
        s_tdata = b.data;
        s_tkeep = b.keep;
        s_tlast = b.last;
        s_tid   = b.id;
        s_tdest = b.dest;
        s_tuser = b.user;
    endtask

    // Hold the offer until its transfer edge, drop valid 1 ns after it
    task automatic finish_beat();
        do begin
            @(negedge clk_ifc);
        end while (!s_tready);
        @(posedge clk_ifc);
        #1;
        s_tvalid = 1'b0;
    endtask

    task automatic send_beat(input stream_pkg::axis_beat_t b);
        apply_beat(b);
        s_tvalid = 1'b1;
        finish_beat();
    endtask

    ////////////////////////////////////////////////////////////
    // Output ready, held level or random phases

    always @(posedge clk_ifc) begin
        #1;
        if (!random_stalls) begin
            m_tready = ready_hold;
        end else if (stall_left == 0) begin
            // Open about two phases in three
            m_tready   = ($urandom_range(0, 2) != 0);
            stall_left = $urandom_range(1, 16);
        end else begin
            stall_left = stall_left - 1;
        end
    end

    // Hang guard
    always @(posedge clk_ifc) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            report_failure($sformatf("Timeout: run still busy after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // Monitor, mid-cycle where handshakes are settled

    always @(negedge clk_ifc) begin
        stream_pkg::axis_beat_t got;
        stream_pkg::axis_beat_t want;
        bit                     match;
        if (monitor_on) begin
            expect_eq("pkts_in", pkts_in, in_lasts);
            expect_eq("pkts_out", pkts_out, out_lasts);
            if (m_tvalid && m_tready) begin
                got = '{data: m_tdata, keep: m_tkeep, last: m_tlast,
                        id: m_tid, dest: m_tdest, user: m_tuser};
                assert (sb.pending() > 0)
                    else report_failure("Output beat delivered while the model expected none");
                sb.pop_compare(got, match, want);
                assert (match)
                    else report_failure($sformatf("Fail %0t: output beat %h, expected %h",
                                                  $time, got, want));
                if (m_tlast) out_lasts = out_lasts + 1'b1;
            end
            // Transfer lands on the coming edge
            if (s_tvalid && s_tready) begin
                sb.push_beat('{data: s_tdata, keep: s_tkeep, last: s_tlast,
                               id: s_tid, dest: s_tdest, user: s_tuser});
                if (s_tlast) in_lasts = in_lasts + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        int                            total_beats;
        int                            nbeats;
        int                            accepted;
        bit                            refused;
        logic [`STREAM_ID_WIDTH-1:0]   pkt_id;
        logic [`STREAM_DEST_WIDTH-1:0] pkt_dest;
        void'($urandom(SEED));
        rst_n    = 1'b0;
        s_tvalid = 1'b0;
        apply_beat('0);
        // Packet sizes first, so the beat total sets the time limit
        total_beats = `FIFO_DEPTH + 4;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_len[p]  = $urandom_range(8, 200);
            total_beats = total_beats + (pkt_len[p] + BYTES - 1) / BYTES;
        end
        cycle_limit = 4 * total_beats + 1000;

        // Reset values, then one closed edge on s_tready
        repeat (5) @(posedge clk_ifc);
        #1;
        expect_eq("m_tvalid in reset", m_tvalid, 0);
        expect_eq("axis_in_overflow in reset", axis_in_overflow, 0);
        rst_n = 1'b1;
        @(negedge clk_ifc);
        expect_eq("s_tready before first edge", s_tready, 0);
        expect_eq("m_tvalid after reset", m_tvalid, 0);
        expect_eq("pkts_in after reset", pkts_in, 0);
        expect_eq("pkts_out after reset", pkts_out, 0);
        ready_hold = 1'b1;
        repeat (3) @(posedge clk_ifc);
        #1;
        monitor_on = 1'b1;

        // Single beat through an empty buffer
        send_beat(random_beat(BYTES, 1'b0, '0, '0));
        @(negedge clk_ifc);
        expect_eq("m_tvalid one edge after accept", m_tvalid, 0);
        @(negedge clk_ifc);
        expect_eq("m_tvalid two edges after accept", m_tvalid, 1);

        // Fill with the output stalled
        @(negedge clk_ifc);
        ready_hold = 1'b0;
        repeat (2) @(posedge clk_ifc);
        #1;
        accepted = 0;
        refused  = 1'b0;
        apply_beat(random_beat(BYTES, 1'b0, '0, '0));
        s_tvalid = 1'b1;
        while (!refused) begin
            @(negedge clk_ifc);
            if (s_tready) begin
                expect_eq("axis_in_overflow while filling", axis_in_overflow, 0);
                accepted = accepted + 1;
                @(posedge clk_ifc);
                #1;
                apply_beat(random_beat(BYTES, 1'b0, '0, '0));
            end else begin
                refused = 1'b1;
            end
        end
        expect_eq("beats accepted before s_tready fell", accepted, `FIFO_DEPTH + 1);
        @(negedge clk_ifc);
        expect_eq("axis_in_overflow after refused beat", axis_in_overflow, 1);
        ready_hold = 1'b1;
        finish_beat();

        // Random packets with input gaps and output stall phases
        @(negedge clk_ifc);
        random_stalls = 1'b1;
        @(posedge clk_ifc);
        #1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_id   = `STREAM_ID_WIDTH'($urandom);
            pkt_dest = `STREAM_DEST_WIDTH'($urandom);
            nbeats   = (pkt_len[p] + BYTES - 1) / BYTES;
            for (int i = 0; i < nbeats; i++) begin
                if ($urandom_range(0, 3) == 0) begin
                    repeat ($urandom_range(1, 4)) @(posedge clk_ifc);
                    #1;
                end
                send_beat(random_beat((i == nbeats - 1) ? pkt_len[p] - BYTES * i : BYTES,
                                      i == nbeats - 1, pkt_id, pkt_dest));
            end
        end

        // Drain with the output open, output goes idle once the buffer is empty
        @(negedge clk_ifc);
        random_stalls = 1'b0;
        do begin
            @(posedge clk_ifc);
            #2;
        end while (m_tvalid);
        expect_eq("pkts_in at end", pkts_in, NUM_PKTS);
        expect_eq("pkts_out at end", pkts_out, NUM_PKTS);
        expect_eq("model queue depth at end", sb.pending(), 0);
        expect_eq("axis_in_overflow at end", axis_in_overflow, 1);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/stream_pkg.sv
src/axis_if.sv
src/axis_ingress.sv
src/dist_ram_fifo.sv
src/axis_egress.sv
src/axis_packet_fifo.sv
test/axis_beat_scoreboard.sv
test/axis_packet_fifo_tb.sv

//--- Makefile
# Verilator build and run for the AXI-Stream packet FIFO
# Override on the command line, e.g. make SEED=12345 LOG=run.log

VERILATOR ?= verilator
TOP       ?= axis_packet_fifo_tb
RTL_TOP   ?= axis_packet_fifo
LOG       ?= sim.log
# Decimal form of 32'hc23c08c4
SEED      ?= 3258714308
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
